/* src/cpuPkg.sv */
package cpuPkg;

	// ----------------------------------------
	// widths that carry a meaning
	typedef logic [15:0] word_t;	// data word, address or instruction
	typedef logic [2:0]  regId_t;	// general register number

	// ----------------------------------------
	// control encodings
	typedef enum logic [2:0]
	{
		aluAdd   = 3'd0,
		aluSub   = 3'd1,
		aluAnd   = 3'd2,
		aluOr    = 3'd3,
		aluPassA = 3'd4	// first operand straight through
	} aluOp_t;

	typedef enum logic [1:0]
	{
		dstRx = 2'd0,
		dstRy = 2'd1,
		dstRz = 2'd2
	} regDst_t;

	typedef enum logic
	{
		srcReg = 1'b0,
		srcImm = 1'b1
	} aluSrc_t;

	typedef enum logic [1:0]
	{
		fwdNone = 2'd0,	// value read in ID
		fwdMem  = 2'd1,	// EX/MEM result
		fwdWb   = 2'd2	// write-back value
	} fwdSel_t;

	// ----------------------------------------
	// major opcodes in bits 15:11
	localparam logic [4:0] opAddiu = 5'b01001;
	localparam logic [4:0] opLi    = 5'b01101;
	localparam logic [4:0] opLw    = 5'b10011;
	localparam logic [4:0] opSw    = 5'b11011;
	localparam logic [4:0] opBeqz  = 5'b00100;
	localparam logic [4:0] opB     = 5'b00010;
	localparam logic [4:0] opNop   = 5'b00001;
	localparam logic [4:0] opRrr   = 5'b11100;	// three register group
	localparam logic [4:0] opRr    = 5'b11101;	// two register group

	// function codes
	localparam logic [1:0] funcAddu = 2'b01;	// bits 1:0
	localparam logic [1:0] funcSubu = 2'b11;
	localparam logic [4:0] funcAnd  = 5'b01100;	// bits 4:0
	localparam logic [4:0] funcOr   = 5'b01101;
	localparam logic [4:0] funcJr   = 5'b00000;

	localparam word_t nopWord = 16'h0800;
	localparam word_t resetPc = 16'h0000;

endpackage

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
	input  cpuPkg::word_t  a,
	input  cpuPkg::word_t  b,
	input  cpuPkg::aluOp_t op,
	output cpuPkg::word_t  result,
	output logic           zero
);

	always_comb
	begin
		case (op)
			cpuPkg::aluAdd:   result = a + b;
			cpuPkg::aluSub:   result = a - b;
			cpuPkg::aluAnd:   result = a & b;
			cpuPkg::aluOr:    result = a | b;
			cpuPkg::aluPassA: result = a;
			default:          result = a + b;
		endcase
	end

	assign zero = (result == '0);	// BEQZ condition

endmodule

/* src/instructionDecoder.sv */
`timescale 1ns/1ps

module instructionDecoder (
	input  cpuPkg::word_t   instr,
	output cpuPkg::aluOp_t  aluOp,
	output cpuPkg::aluSrc_t aluSrc,
	output cpuPkg::regDst_t regDst,
	output logic            regWrite,
	output logic            memRead,
	output logic            memWrite,
	output logic            memToReg,
	output logic            branch,
	output logic            branchAlways,
	output logic            jump,
	output cpuPkg::word_t   imm
);

	always_comb
	begin
		// anything unrecognised falls through as a NOP
		aluOp        = cpuPkg::aluAdd;
		aluSrc       = cpuPkg::srcReg;
		regDst       = cpuPkg::dstRx;
		regWrite     = 1'b0;
		memRead      = 1'b0;
		memWrite     = 1'b0;
		memToReg     = 1'b0;
		branch       = 1'b0;
		branchAlways = 1'b0;
		jump         = 1'b0;
		imm          = {{8{instr[7]}}, instr[7:0]};	// signed imm8

		case (instr[15:11])
			cpuPkg::opAddiu:
			begin
				regWrite = 1'b1;
				aluSrc   = cpuPkg::srcImm;
			end
			cpuPkg::opLi:
			begin
				regWrite = 1'b1;
				aluSrc   = cpuPkg::srcImm;
				aluOp    = cpuPkg::aluPassA;	// immediate is the first operand
				imm      = {8'b0, instr[7:0]};
			end
			cpuPkg::opLw:
			begin
				regWrite = 1'b1;
				memRead  = 1'b1;
				memToReg = 1'b1;
				aluSrc   = cpuPkg::srcImm;
				regDst   = cpuPkg::dstRy;
				imm      = {{11{instr[4]}}, instr[4:0]};
			end
			cpuPkg::opSw:
			begin
				memWrite = 1'b1;
				aluSrc   = cpuPkg::srcImm;
				imm      = {{11{instr[4]}}, instr[4:0]};
			end
			cpuPkg::opBeqz:
			begin
				branch = 1'b1;
				aluOp  = cpuPkg::aluPassA;	// zero flag then tests rx
			end
			cpuPkg::opB:
			begin
				branchAlways = 1'b1;
				imm          = {{5{instr[10]}}, instr[10:0]};
			end
			cpuPkg::opRrr:
			begin
				regDst = cpuPkg::dstRz;
				case (instr[1:0])
					cpuPkg::funcAddu: regWrite = 1'b1;
					cpuPkg::funcSubu:
					begin
						regWrite = 1'b1;
						aluOp    = cpuPkg::aluSub;
					end
					default: regWrite = 1'b0;
				endcase
			end
			cpuPkg::opRr:
			begin
				case (instr[4:0])
					cpuPkg::funcAnd:
					begin
						regWrite = 1'b1;
						aluOp    = cpuPkg::aluAnd;
					end
					cpuPkg::funcOr:
					begin
						regWrite = 1'b1;
						aluOp    = cpuPkg::aluOr;
					end
					cpuPkg::funcJr: jump = 1'b1;	// target is rx
					default: jump = 1'b0;
				endcase
			end
			cpuPkg::opNop: regWrite = 1'b0;
			default: regWrite = 1'b0;
		endcase
	end

endmodule

/* src/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
	input  logic           CLK,
	input  logic           RST,
	input  cpuPkg::regId_t readA,
	input  cpuPkg::regId_t readB,
	output cpuPkg::word_t  readDataA,
	output cpuPkg::word_t  readDataB,
	input  logic           writeEn,
	input  cpuPkg::regId_t writeReg,
	input  cpuPkg::word_t  writeData
);

	cpuPkg::word_t regs [0:7];

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end
		else if (writeEn)
		begin
			regs[writeReg] <= writeData;
		end
	end

	// same-cycle write shows up on the read ports
	assign readDataA = (writeEn && writeReg == readA) ? writeData : regs[readA];
	assign readDataB = (writeEn && writeReg == readB) ? writeData : regs[readB];

endmodule

/* src/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
	input  cpuPkg::regId_t  idRx,
	input  cpuPkg::regId_t  idRy,
	input  logic            exMemRead,
	input  cpuPkg::regId_t  exDest,
	input  logic            memRegWrite,
	input  logic            wbRegWrite,
	input  cpuPkg::regId_t  memDest,
	input  cpuPkg::regId_t  wbDest,
	input  cpuPkg::regId_t  exRx,
	input  cpuPkg::regId_t  exRy,
	output logic            stall,
	output cpuPkg::fwdSel_t fwdA,
	output cpuPkg::fwdSel_t fwdB
);

	// ----------------------------------------
	// load-use
	// the loaded value only exists after MEM, so the reader in ID waits one
	// cycle and then picks it up from write-back
	assign stall = exMemRead && (exDest == idRx || exDest == idRy);

	// ----------------------------------------
	// forwarding
	function automatic cpuPkg::fwdSel_t pickSource(cpuPkg::regId_t src);
		if (memRegWrite && memDest == src)
			return cpuPkg::fwdMem;	// youngest result wins
		else if (wbRegWrite && wbDest == src)
			return cpuPkg::fwdWb;
		else
			return cpuPkg::fwdNone;
	endfunction

	assign fwdA = pickSource(exRx);
	assign fwdB = pickSource(exRy);

endmodule

/* src/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
	input  cpuPkg::word_t   pc,
	input  cpuPkg::word_t   rxData,
	input  cpuPkg::word_t   ryData,
	input  cpuPkg::word_t   imm,
	input  cpuPkg::word_t   memResult,
	input  cpuPkg::word_t   wbResult,
	input  cpuPkg::fwdSel_t fwdA,
	input  cpuPkg::fwdSel_t fwdB,
	input  cpuPkg::aluSrc_t aluSrc,
	input  cpuPkg::aluOp_t  aluOp,
	input  cpuPkg::regDst_t regDst,
	input  cpuPkg::regId_t  rx,
	input  cpuPkg::regId_t  ry,
	input  cpuPkg::regId_t  rz,
	output cpuPkg::word_t   result,
	output cpuPkg::word_t   storeData,
	output cpuPkg::word_t   branchTarget,
	output cpuPkg::word_t   jumpTarget,
	output logic            zero,
	output cpuPkg::regId_t  dest
);

	cpuPkg::word_t rxFwd;
	cpuPkg::word_t ryFwd;
	cpuPkg::word_t opA;
	cpuPkg::word_t opB;

	function automatic cpuPkg::word_t forwardValue(cpuPkg::fwdSel_t sel, cpuPkg::word_t regValue);
		case (sel)
			cpuPkg::fwdMem: return memResult;
			cpuPkg::fwdWb:  return wbResult;
			default:        return regValue;
		endcase
	endfunction

	assign rxFwd = forwardValue(fwdA, rxData);
	assign ryFwd = forwardValue(fwdB, ryData);

	// ----------------------------------------
	// operands
	// immediate forms put imm first and rx second, so pass-first yields LI
	// and add stays add for ADDIU, LW and SW
	assign opA = (aluSrc == cpuPkg::srcImm) ? imm : rxFwd;
	assign opB = (aluSrc == cpuPkg::srcImm) ? rxFwd : ryFwd;

	alu aluUnit (
		.a      (opA),
		.b      (opB),
		.op     (aluOp),
		.result (result),
		.zero   (zero)
	);

	always_comb
	begin
		case (regDst)
			cpuPkg::dstRy: dest = ry;
			cpuPkg::dstRz: dest = rz;
			default:       dest = rx;
		endcase
	end

	assign storeData    = ryFwd;	// SW stores ry
	assign branchTarget = pc + imm;	// pc is already branch address + 1
	assign jumpTarget   = rxFwd;

endmodule

/* src/pipelineCpu.sv */
`timescale 1ns/1ps

module pipelineCpu (
	input  logic           CLK,
	input  logic           RST,
	input  cpuPkg::word_t  imemData,
	input  cpuPkg::word_t  dataRdata,
	output cpuPkg::word_t  imemAddr,
	output cpuPkg::word_t  dataAddr,
	output cpuPkg::word_t  dataWdata,
	output logic           dataRead,
	output logic           dataWrite,
	output logic           wbValid,
	output cpuPkg::regId_t wbReg,
	output cpuPkg::word_t  wbData
);

	// fetch and IF/ID
	cpuPkg::word_t pc;
	cpuPkg::word_t nextPc;
	cpuPkg::word_t ifIdInstr;
	cpuPkg::word_t ifIdPc;

	// decode
	cpuPkg::aluOp_t  idAluOp;
	cpuPkg::aluSrc_t idAluSrc;
	cpuPkg::regDst_t idRegDst;
	cpuPkg::word_t   idImm;
	cpuPkg::word_t   idRxData;
	cpuPkg::word_t   idRyData;
	logic idRegWrite, idMemRead, idMemWrite, idMemToReg;
	logic idBranch, idBranchAlways, idJump;

	// ID/EX
	cpuPkg::word_t   idExPc, idExRxData, idExRyData, idExImm;
	cpuPkg::regId_t  idExRx, idExRy, idExRz;
	cpuPkg::aluOp_t  idExAluOp;
	cpuPkg::aluSrc_t idExAluSrc;
	cpuPkg::regDst_t idExRegDst;
	logic idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg;
	logic idExBranch, idExBranchAlways, idExJump;

	// execute
	cpuPkg::word_t   exResult, exStoreData, exBranchTarget, exJumpTarget;
	logic            exZero;
	cpuPkg::regId_t  exDest;
	cpuPkg::fwdSel_t fwdA, fwdB;

	// EX/MEM
	cpuPkg::word_t  exMemResult, exMemStoreData, exMemBranchTarget;
	logic           exMemZero;
	cpuPkg::regId_t exMemDest;
	logic exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg;
	logic exMemBranch, exMemBranchAlways;

	// MEM/WB
	cpuPkg::word_t  memWbResult, memWbLoadData;
	cpuPkg::regId_t memWbDest;
	logic           memWbRegWrite, memWbMemToReg;

	logic stall;
	logic branchTaken;
	logic jumpTaken;
	logic flushFront;

	// ----------------------------------------
	// redirect and flush
	assign branchTaken = (exMemBranch && exMemZero) || exMemBranchAlways;	// resolves in MEM
	assign jumpTaken   = idExJump && !branchTaken;	// older branch wins
	assign flushFront  = branchTaken || jumpTaken;

	always_comb
	begin
		if (branchTaken)
			nextPc = exMemBranchTarget;
		else if (jumpTaken)
			nextPc = exJumpTarget;
		else if (stall)
			nextPc = pc;	// hold for load-use
		else
			nextPc = pc + 16'd1;
	end

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			pc        <= cpuPkg::resetPc;
			ifIdInstr <= cpuPkg::nopWord;
		end
		else
		begin
			pc <= nextPc;
			if (flushFront)
				ifIdInstr <= cpuPkg::nopWord;	// drop the fetched word
			else if (!stall)
				ifIdInstr <= imemData;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!stall)
			ifIdPc <= pc + 16'd1;
	end

	assign imemAddr = pc;

	// ----------------------------------------
	// decode
	instructionDecoder decoder (
		.instr        (ifIdInstr),
		.aluOp        (idAluOp),
		.aluSrc       (idAluSrc),
		.regDst       (idRegDst),
		.regWrite     (idRegWrite),
		.memRead      (idMemRead),
		.memWrite     (idMemWrite),
		.memToReg     (idMemToReg),
		.branch       (idBranch),
		.branchAlways (idBranchAlways),
		.jump         (idJump),
		.imm          (idImm)
	);

	registerFile regFile (
		.CLK       (CLK),
		.RST       (RST),
		.readA     (ifIdInstr[10:8]),
		.readB     (ifIdInstr[7:5]),
		.readDataA (idRxData),
		.readDataB (idRyData),
		.writeEn   (wbValid),
		.writeReg  (wbReg),
		.writeData (wbData)
	);

	hazardUnit hazard (
		.idRx        (ifIdInstr[10:8]),
		.idRy        (ifIdInstr[7:5]),
		.exMemRead   (idExMemRead),
		.exDest      (exDest),
		.memRegWrite (exMemRegWrite),
		.wbRegWrite  (memWbRegWrite),
		.memDest     (exMemDest),
		.wbDest      (memWbDest),
		.exRx        (idExRx),
		.exRy        (idExRy),
		.stall       (stall),
		.fwdA        (fwdA),
		.fwdB        (fwdB)
	);

	// ID/EX takes a bubble on stall or flush
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			{idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg} <= '0;
			{idExBranch, idExBranchAlways, idExJump} <= '0;
		end
		else if (flushFront || stall)
		begin
			{idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg} <= '0;
			{idExBranch, idExBranchAlways, idExJump} <= '0;
		end
		else
		begin
			{idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg} <=
				{idRegWrite, idMemRead, idMemWrite, idMemToReg};
			{idExBranch, idExBranchAlways, idExJump} <= {idBranch, idBranchAlways, idJump};
		end
	end

	always_ff @(posedge CLK)
	begin
		idExPc     <= ifIdPc;
		idExRxData <= idRxData;
		idExRyData <= idRyData;
		idExImm    <= idImm;
		idExRx     <= ifIdInstr[10:8];
		idExRy     <= ifIdInstr[7:5];
		idExRz     <= ifIdInstr[4:2];
		idExAluOp  <= idAluOp;
		idExAluSrc <= idAluSrc;
		idExRegDst <= idRegDst;
	end

	// ----------------------------------------
	// execute
	executeStage execute (
		.pc           (idExPc),
		.rxData       (idExRxData),
		.ryData       (idExRyData),
		.imm          (idExImm),
		.memResult    (exMemResult),
		.wbResult     (wbData),
		.fwdA         (fwdA),
		.fwdB         (fwdB),
		.aluSrc       (idExAluSrc),
		.aluOp        (idExAluOp),
		.regDst       (idExRegDst),
		.rx           (idExRx),
		.ry           (idExRy),
		.rz           (idExRz),
		.result       (exResult),
		.storeData    (exStoreData),
		.branchTarget (exBranchTarget),
		.jumpTarget   (exJumpTarget),
		.zero         (exZero),
		.dest         (exDest)
	);

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			{exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg} <= '0;
			{exMemBranch, exMemBranchAlways} <= '0;
		end
		else if (branchTaken)	// third younger instruction dies here
		begin
			{exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg} <= '0;
			{exMemBranch, exMemBranchAlways} <= '0;
		end
		else
		begin
			{exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg} <=
				{idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg};
			{exMemBranch, exMemBranchAlways} <= {idExBranch, idExBranchAlways};
		end
	end

	always_ff @(posedge CLK)
	begin
		exMemResult       <= exResult;
		exMemStoreData    <= exStoreData;
		exMemBranchTarget <= exBranchTarget;
		exMemZero         <= exZero;
		exMemDest         <= exDest;
	end

	// ----------------------------------------
	// memory and write-back
	assign dataAddr  = exMemResult;
	assign dataWdata = exMemStoreData;
	assign dataRead  = exMemMemRead;
	assign dataWrite = exMemMemWrite;	// one strobe per store

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			memWbRegWrite <= 1'b0;
			memWbMemToReg <= 1'b0;
		end
		else
		begin
			memWbRegWrite <= exMemRegWrite;
			memWbMemToReg <= exMemMemToReg;
		end
	end

	always_ff @(posedge CLK)
	begin
		memWbResult   <= exMemResult;
		memWbLoadData <= dataRdata;
		memWbDest     <= exMemDest;
	end

	assign wbValid = memWbRegWrite;
	assign wbReg   = memWbDest;
	assign wbData  = memWbMemToReg ? memWbLoadData : memWbResult;

endmodule

/* dv/cpuModel.sv */
`timescale 1ns/1ps

module cpuModel;

	cpuPkg::word_t  imem [0:63];
	cpuPkg::word_t  dmem [0:65535];
	cpuPkg::word_t  regs [0:7];
	cpuPkg::regId_t wbRegQ[$];
	cpuPkg::word_t  wbValQ[$];
	cpuPkg::word_t  stAddrQ[$];
	cpuPkg::word_t  stDataQ[$];
	cpuPkg::word_t  ldAddrQ[$];

	task automatic setInstr(input int addr, input cpuPkg::word_t w);
		imem[addr] = w;
	endtask

	task automatic setData(input int addr, input cpuPkg::word_t d);
		dmem[addr] = d;
	endtask

	function automatic int wbPending();
		return wbRegQ.size();
	endfunction

	function automatic int storePending();
		return stAddrQ.size();
	endfunction

	function automatic int loadPending();
		return ldAddrQ.size();
	endfunction

	task automatic popWb(output cpuPkg::regId_t r, output cpuPkg::word_t v);
		r = wbRegQ.pop_front();
		v = wbValQ.pop_front();
	endtask

	task automatic popStore(output cpuPkg::word_t a, output cpuPkg::word_t d);
		a = stAddrQ.pop_front();
		d = stDataQ.pop_front();
	endtask

	task automatic popLoad(output cpuPkg::word_t a);
		a = ldAddrQ.pop_front();
	endtask

	task automatic writeReg(input cpuPkg::regId_t r, input cpuPkg::word_t v);
		regs[r] = v;
		wbRegQ.push_back(r);
		wbValQ.push_back(v);
	endtask

	// ----------------------------------------
	// ISA-level execution up to the halt loop
	task automatic run(input int haltAddr, output bit finished);
		cpuPkg::word_t pc;
		cpuPkg::word_t ins;
		cpuPkg::word_t addr;
		cpuPkg::regId_t rx;
		cpuPkg::regId_t ry;
		int steps;
		wbRegQ.delete();
		wbValQ.delete();
		stAddrQ.delete();
		stDataQ.delete();
		ldAddrQ.delete();
		for (int i = 0; i < 8; i++)
			regs[i] = '0;
		pc = cpuPkg::resetPc;
		steps = 0;
		while (pc != haltAddr && steps < 1000)
		begin
			ins = (pc < 64) ? imem[pc[5:0]] : cpuPkg::nopWord;
			rx = ins[10:8];
			ry = ins[7:5];
			pc = pc + 16'd1;	// targets are relative to the next word
			steps++;
			case (ins[15:11])
				cpuPkg::opAddiu: writeReg(rx, regs[rx] + {{8{ins[7]}}, ins[7:0]});
				cpuPkg::opLi:    writeReg(rx, {8'b0, ins[7:0]});
				cpuPkg::opLw:
				begin
					addr = regs[rx] + {{11{ins[4]}}, ins[4:0]};
					ldAddrQ.push_back(addr);
					writeReg(ry, dmem[addr]);
				end
				cpuPkg::opSw:
				begin
					addr = regs[rx] + {{11{ins[4]}}, ins[4:0]};
					dmem[addr] = regs[ry];
					stAddrQ.push_back(addr);
					stDataQ.push_back(regs[ry]);
				end
				cpuPkg::opBeqz:
					if (regs[rx] == '0)
						pc = pc + {{8{ins[7]}}, ins[7:0]};
				cpuPkg::opB: pc = pc + {{5{ins[10]}}, ins[10:0]};
				cpuPkg::opRrr:
					if (ins[1:0] == cpuPkg::funcAddu)
						writeReg(ins[4:2], regs[rx] + regs[ry]);
					else if (ins[1:0] == cpuPkg::funcSubu)
						writeReg(ins[4:2], regs[rx] - regs[ry]);
				cpuPkg::opRr:
					if (ins[4:0] == cpuPkg::funcAnd)
						writeReg(rx, regs[rx] & regs[ry]);
					else if (ins[4:0] == cpuPkg::funcOr)
						writeReg(rx, regs[rx] | regs[ry]);
					else if (ins[4:0] == cpuPkg::funcJr)
						pc = regs[rx];
				default: ;	// NOP
			endcase
		end
		finished = (pc == haltAddr);
	endtask

endmodule

/* dv/tbProgram.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// instruction assembly into imem and the reference model

task automatic emitWord(input cpuPkg::word_t w);
	imem[progLen] = w;
	model.setInstr(progLen, w);
	progLen++;
endtask

task automatic clearProgram();
	for (int i = 0; i < imemWords; i++)
	begin
		imem[i] = cpuPkg::nopWord;
		model.setInstr(i, cpuPkg::nopWord);
	end
	progLen = 0;
endtask

task automatic addImm(input cpuPkg::regId_t rx, input logic [7:0] imm);
	emitWord({cpuPkg::opAddiu, rx, imm});
endtask

task automatic loadImm(input cpuPkg::regId_t rx, input logic [7:0] imm);
	emitWord({cpuPkg::opLi, rx, imm});
endtask

task automatic loadMem(input cpuPkg::regId_t rx, input cpuPkg::regId_t ry, input logic [4:0] imm);
	emitWord({cpuPkg::opLw, rx, ry, imm});	// ry = mem[rx + imm]
endtask

task automatic storeMem(input cpuPkg::regId_t rx, input cpuPkg::regId_t ry, input logic [4:0] imm);
	emitWord({cpuPkg::opSw, rx, ry, imm});
endtask

task automatic branchIfZero(input cpuPkg::regId_t rx, input logic [7:0] offset);
	emitWord({cpuPkg::opBeqz, rx, offset});
endtask

task automatic branchAlways(input logic [10:0] offset);
	emitWord({cpuPkg::opB, offset});
endtask

task automatic addRegs(input cpuPkg::regId_t rx, input cpuPkg::regId_t ry, input cpuPkg::regId_t rz);
	emitWord({cpuPkg::opRrr, rx, ry, rz, cpuPkg::funcAddu});
endtask

task automatic subRegs(input cpuPkg::regId_t rx, input cpuPkg::regId_t ry, input cpuPkg::regId_t rz);
	emitWord({cpuPkg::opRrr, rx, ry, rz, cpuPkg::funcSubu});
endtask

task automatic andRegs(input cpuPkg::regId_t rx, input cpuPkg::regId_t ry);
	emitWord({cpuPkg::opRr, rx, ry, cpuPkg::funcAnd});
endtask

task automatic orRegs(input cpuPkg::regId_t rx, input cpuPkg::regId_t ry);
	emitWord({cpuPkg::opRr, rx, ry, cpuPkg::funcOr});
endtask

task automatic jumpReg(input cpuPkg::regId_t rx);
	emitWord({cpuPkg::opRr, rx, 3'b000, cpuPkg::funcJr});
endtask

// padding keeps branch shadows clear of the halt loop
task automatic closeProgram();
	for (int i = 0; i < 4; i++)
		emitWord(cpuPkg::nopWord);
	haltAddr = progLen;
	branchAlways(11'h7ff);	// B -1 spins in place
endtask

`endif

/* dv/pipelineCpuTb.sv */
`timescale 1ns/1ps

module pipelineCpuTb;

	localparam int imemWords   = 64;
	localparam int drainCycles = 6;	// pipeline depth plus margin

	logic           CLK;
	logic           RST;
	cpuPkg::word_t  imemData;
	cpuPkg::word_t  dataRdata;
	cpuPkg::word_t  imemAddr;
	cpuPkg::word_t  dataAddr;
	cpuPkg::word_t  dataWdata;
	logic           dataRead;
	logic           dataWrite;
	logic           wbValid;
	cpuPkg::regId_t wbReg;
	cpuPkg::word_t  wbData;

	cpuPkg::word_t  imem [0:imemWords-1];
	cpuPkg::word_t  dmem [0:65535];
	int             progLen;
	int             haltAddr;
	int             cycleCount;
	int             cycleLimit;
	int             testErrors;
	int             passCount;
	int             failCount;
	logic           checking;
	cpuPkg::regId_t expReg;
	cpuPkg::word_t  expVal;
	cpuPkg::word_t  expAddr;
	cpuPkg::word_t  expData;
	cpuPkg::word_t  expLoad;

	pipelineCpu uut (
		.CLK       (CLK),
		.RST       (RST),
		.imemData  (imemData),
		.dataRdata (dataRdata),
		.imemAddr  (imemAddr),
		.dataAddr  (dataAddr),
		.dataWdata (dataWdata),
		.dataRead  (dataRead),
		.dataWrite (dataWrite),
		.wbValid   (wbValid),
		.wbReg     (wbReg),
		.wbData    (wbData)
	);

	cpuModel model ();

	`include "tbProgram.svh"

	initial CLK = 1'b0;
	always #10 CLK = ~CLK;

	// memories answer in the same cycle
	assign imemData  = (imemAddr < imemWords) ? imem[imemAddr[5:0]] : cpuPkg::nopWord;
	assign dataRdata = dmem[dataAddr];

	always @(posedge CLK)
		if (RST && dataWrite)
			dmem[dataAddr] <= dataWdata;

	always @(posedge CLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("timeout: the run hung after %0d cycles", cycleCount);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// in-order checks against the model queues
	always @(negedge CLK)
	begin
		if (RST && checking && wbValid)
		begin
			assert (model.wbPending() != 0)
			else
			begin
				testErrors++;
				$display("write-back to r%0d that the program never makes", wbReg);
			end
			if (model.wbPending() != 0)
			begin
				model.popWb(expReg, expVal);
				assert (wbReg == expReg)
				else
				begin
					testErrors++;
					$display("ERROR wbReg: got 0x%h, expected 0x%h", wbReg, expReg);
				end
				assert (wbData == expVal)
				else
				begin
					testErrors++;
					$display("ERROR wbData: got 0x%h, expected 0x%h", wbData, expVal);
				end
			end
		end
		if (RST && checking && dataWrite)
		begin
			assert (model.storePending() != 0)
			else
			begin
				testErrors++;
				$display("store to 0x%h that the program never makes", dataAddr);
			end
			if (model.storePending() != 0)
			begin
				model.popStore(expAddr, expData);
				assert (dataAddr == expAddr)
				else
				begin
					testErrors++;
					$display("ERROR dataAddr: got 0x%h, expected 0x%h", dataAddr, expAddr);
				end
				assert (dataWdata == expData)
				else
				begin
					testErrors++;
					$display("ERROR dataWdata: got 0x%h, expected 0x%h", dataWdata, expData);
				end
			end
		end
		if (RST && checking && dataRead)
		begin
			assert (model.loadPending() != 0)
			else
			begin
				testErrors++;
				$display("load from 0x%h that the program never makes", dataAddr);
			end
			if (model.loadPending() != 0)
			begin
				model.popLoad(expLoad);
				assert (dataAddr == expLoad)
				else
				begin
					testErrors++;
					$display("ERROR dataAddr: got 0x%h, expected 0x%h", dataAddr, expLoad);
				end
			end
		end
	end

	// ----------------------------------------
	// test sequencing
	task automatic startTest();
		@(posedge CLK);
		RST <= 1'b0;
		checking = 1'b0;
		testErrors = 0;
		clearProgram();
	endtask

	task automatic finishTest(input string name);
		bit done;
		closeProgram();
		for (int a = 0; a < 65536; a++)
		begin
			dmem[a] = a[15:0] * 16'h9e37 ^ 16'h5a5a;	// distinct value at every address
			model.setData(a, dmem[a]);
		end
		model.run(haltAddr, done);
		assert (done)
		else
		begin
			testErrors++;
			$display("reference model never reached the halt loop");
		end
		cycleLimit += 4 * progLen + 20;
		repeat (3) @(posedge CLK);
		RST <= 1'b1;
		@(negedge CLK);
		assert (imemAddr == cpuPkg::resetPc)
		else
		begin
			testErrors++;
			$display("ERROR imemAddr after reset: got 0x%h, expected 0x%h", imemAddr,
				cpuPkg::resetPc);
		end
		assert (!wbValid && !dataWrite && !dataRead)
		else
		begin
			testErrors++;
			$display("a write-back or memory access is active right after reset");
		end
		checking = 1'b1;
		while (imemAddr != haltAddr)
			@(negedge CLK);
		repeat (drainCycles) @(negedge CLK);
		assert (model.wbPending() == 0 && model.storePending() == 0 &&
			model.loadPending() == 0)
		else
		begin
			testErrors++;
			$display("expected events never appeared: %0d write-backs, %0d stores, %0d loads",
				model.wbPending(), model.storePending(), model.loadPending());
		end
		if (testErrors == 0)
			passCount++;
		else
			failCount++;
		$display("test %s: %s with %0d errors", name, (testErrors == 0) ? "ok" : "bad",
			testErrors);
	endtask

	initial
	begin
		cpuPkg::regId_t prev;
		cpuPkg::regId_t other;
		cpuPkg::regId_t dest;
		int target;
		void'($urandom(6392));
		RST = 1'b0;
		checking = 1'b0;
		cycleCount = 0;
		cycleLimit = 20;
		passCount = 0;
		failCount = 0;
		progLen = 0;

		startTest();
		loadImm(1, 8'h05);
		addImm(1, 8'hfd);
		finishTest("reset");

		// dependent chains exercise both forwarding paths
		startTest();
		for (int r = 0; r < 8; r++)
			loadImm(r, $urandom);
		prev = $urandom;
		for (int i = 0; i < 16; i++)
		begin
			other = $urandom;
			dest = $urandom;
			case ($urandom % 6)
				0: loadImm(prev, $urandom);
				1: addImm(prev, $urandom);
				2:
				begin
					addRegs(prev, other, dest);
					prev = dest;
				end
				3:
				begin
					subRegs(prev, other, dest);
					prev = dest;
				end
				4: andRegs(prev, other);
				default: orRegs(prev, other);
			endcase
		end
		finishTest("arithmetic");

		startTest();
		for (int i = 0; i < 3; i++)
		begin
			loadImm(1, $urandom);
			loadImm(2, $urandom);
			storeMem(1, 2, 5'd3);
			loadMem(1, 3, 5'd3);
			addRegs(3, 2, 4);	// reads the load at once
			loadMem(1, 5, 5'h1e);
			addImm(5, 8'h01);
			loadMem(1, 6, 5'd4);
			storeMem(1, 6, 5'd7);	// load data as store data
		end
		finishTest("load-use");

		startTest();
		loadImm(1, 8'h00);
		branchIfZero(1, 8'd2);	// taken
		loadImm(2, 8'h11);
		storeMem(1, 2, 5'd0);
		loadImm(4, 8'h33);
		loadImm(5, 8'h07);
		branchIfZero(5, 8'd1);	// not taken
		addImm(5, 8'h01);
		branchAlways(11'd3);
		loadImm(6, 8'h66);
		storeMem(1, 6, 5'd1);
		loadImm(7, 8'h77);
		subRegs(5, 5, 3);
		branchIfZero(3, 8'd1);	// zero from a forwarded result
		loadImm(7, 8'h99);
		addImm(4, 8'h01);
		finishTest("branch");

		startTest();
		target = progLen + 5;
		loadImm(1, target);
		jumpReg(1);
		loadImm(2, 8'haa);
		loadImm(3, 8'hbb);
		storeMem(1, 2, 5'd0);
		addImm(1, 8'h01);
		orRegs(1, 1);
		finishTest("jump");

		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+dv
src/cpuPkg.sv
src/alu.sv
src/instructionDecoder.sv
src/registerFile.sv
src/hazardUnit.sv
src/executeStage.sv
src/pipelineCpu.sv
dv/cpuModel.sv
dv/pipelineCpuTb.sv
